// ==== hw/vram_pkg.sv ====
package vram_pkg;

    // hack screen geometry inside the 640x480 raster
    localparam int HACK_SCREEN_WIDTH  = 512;
    localparam int HACK_SCREEN_HEIGHT = 256;
    localparam int HACK_H_OFFSET      = 64;
    localparam int HACK_V_OFFSET      = 112;
    localparam int WORDS_PER_ROW      = 32;
    localparam int NIBBLES_PER_ROW    = 128;

    // 23LC1024 command codes
    localparam logic [7:0] INS_RSTIO = 8'hFF;
    localparam logic [7:0] INS_EQIO  = 8'h38;
    localparam logic [7:0] INS_READ  = 8'h03;
    localparam logic [7:0] INS_WRITE = 8'h02;

    localparam int READ_DUMMY_SCK = 2;
    localparam int FIFO_DEPTH     = 16;

    // serial clock counts per transaction
    localparam int SPI_CMD_SCK     = 8;
    localparam int QUAD_HEADER_SCK = 8;
    localparam int READ_DATA_SCK   = QUAD_HEADER_SCK + READ_DUMMY_SCK;
    localparam int QUAD_READ_SCK   = READ_DATA_SCK + NIBBLES_PER_ROW;
    localparam int QUAD_WRITE_SCK  = QUAD_HEADER_SCK + 4;

    typedef logic [15:0] word_t;
    typedef logic [12:0] vram_addr_t;
    typedef logic [23:0] sram_addr_t;
    typedef logic [7:0]  row_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [9:0]  pos_t;

    typedef enum logic [1:0] {
        op_rstio,
        op_eqio,
        op_read_row,
        op_write_word
    } qspi_op_e;

    typedef enum logic [2:0] {
        st_reset_io,
        st_enter_quad,
        st_idle,
        st_read,
        st_write
    } seq_state_e;

    typedef struct packed {
        qspi_op_e   op;
        sram_addr_t addr;
        word_t      data;
    } qspi_req_t;

    typedef struct packed {
        vram_addr_t addr;
        word_t      data;
    } vram_write_t;

endpackage

// ==== hw/vram_write_fifo.sv ====
`timescale 1ns/10ps

module vram_write_fifo (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push_i,
    input  vram_pkg::vram_write_t push_data_i,
    input  logic                  pop_i,
    output vram_pkg::vram_write_t head_o,
    output logic                  empty_o,
    output logic                  full_o
);

    vram_pkg::vram_write_t mem [vram_pkg::FIFO_DEPTH];

    logic [$clog2(vram_pkg::FIFO_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(vram_pkg::FIFO_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(vram_pkg::FIFO_DEPTH):0]   count_q;
    logic                                    do_push;
    logic                                    do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == vram_pkg::FIFO_DEPTH);
    assign head_o  = mem[rd_ptr_q];

    // writes while full and reads while empty are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== hw/sram_qspi_phy.sv ====
`timescale 1ns/10ps

module sram_qspi_phy (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid_i,
    input  vram_pkg::qspi_req_t req_i,
    output logic                idle_o,
    output logic                done_o,
    output logic                nib_valid_o,
    output vram_pkg::nibble_t   nib_o,
    output logic                sram_cs_n_o,
    output logic                sram_sck_o,
    output logic                sram_sio_oe_o,
    output vram_pkg::nibble_t   sram_sio_o,
    input  vram_pkg::nibble_t   sram_sio_i
);

    logic               cs_n_q;
    logic               sck_q;
    logic               oe_q;
    logic               done_q;
    logic               nib_valid_q;
    logic [7:0]         sck_cnt_q;
    logic [7:0]         sck_total;
    logic [47:0]        shift_q;
    logic [7:0]         cmd;
    vram_pkg::word_t    data_rev;
    vram_pkg::qspi_op_e op_q;
    vram_pkg::nibble_t  nib_q;
    logic               quad;
    logic               accept;

    assign idle_o        = cs_n_q && !done_q;
    assign accept        = idle_o && req_valid_i;
    assign done_o        = done_q;
    assign nib_valid_o   = nib_valid_q;
    assign nib_o         = nib_q;
    assign sram_cs_n_o   = cs_n_q;
    assign sram_sck_o    = sck_q;
    assign sram_sio_oe_o = oe_q;

    assign quad = (op_q == vram_pkg::op_read_row) || (op_q == vram_pkg::op_write_word);

    // spi mode keeps HOLD_N (sio3) high and sends on sio0
    assign sram_sio_o = quad ? shift_q[47:44] : {1'b1, 2'b00, shift_q[47]};

    always_comb begin
        case (req_i.op)
            vram_pkg::op_rstio:     cmd = vram_pkg::INS_RSTIO;
            vram_pkg::op_eqio:      cmd = vram_pkg::INS_EQIO;
            vram_pkg::op_read_row:  cmd = vram_pkg::INS_READ;
            default:                cmd = vram_pkg::INS_WRITE;
        endcase
        // hack pixel 0 is word bit 0, so it goes out first
        for (int i = 0; i < 16; i++) begin
            data_rev[i] = req_i.data[15-i];
        end
    end

    always_comb begin
        case (op_q)
            vram_pkg::op_read_row:   sck_total = 8'(vram_pkg::QUAD_READ_SCK);
            vram_pkg::op_write_word: sck_total = 8'(vram_pkg::QUAD_WRITE_SCK);
            default:                 sck_total = 8'(vram_pkg::SPI_CMD_SCK);
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cs_n_q      <= 1'b1;
            sck_q       <= 1'b0;
            oe_q        <= 1'b1;
            done_q      <= 1'b0;
            nib_valid_q <= 1'b0;
            sck_cnt_q   <= '0;
            op_q        <= vram_pkg::op_rstio;
        end else begin
            done_q      <= 1'b0;
            nib_valid_q <= 1'b0;
            if (accept) begin
                cs_n_q    <= 1'b0;
                sck_q     <= 1'b0;
                oe_q      <= 1'b1;
                sck_cnt_q <= '0;
                op_q      <= req_i.op;
            end else if (!cs_n_q) begin
                if (!sck_q) begin
                    // rising edge of sck
                    sck_q     <= 1'b1;
                    sck_cnt_q <= sck_cnt_q + 1'b1;
                    if (op_q == vram_pkg::op_read_row &&
                        sck_cnt_q >= 8'(vram_pkg::READ_DATA_SCK)) begin
                        nib_valid_q <= 1'b1;
                    end
                end else if (sck_cnt_q == sck_total) begin
                    cs_n_q <= 1'b1;
                    sck_q  <= 1'b0;
                    oe_q   <= 1'b1;
                    done_q <= 1'b1;
                end else begin
                    sck_q <= 1'b0;
                    // hand the bus to the sram for the dummy clocks
                    if (op_q == vram_pkg::op_read_row &&
                        sck_cnt_q == 8'(vram_pkg::QUAD_HEADER_SCK)) begin
                        oe_q <= 1'b0;
                    end
                end
            end
        end
    end

    // shift on falling sck, sample on rising sck
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= {cmd, req_i.addr, data_rev};
        end else if (!cs_n_q && sck_q) begin
            shift_q <= quad ? (shift_q << 4) : (shift_q << 1);
        end
        if (!cs_n_q && !sck_q) begin
            nib_q <= sram_sio_i;
        end
    end

endmodule

// ==== hw/vram_sequencer.sv ====
`timescale 1ns/10ps

module vram_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  vram_pkg::pos_t        display_hpos_i,
    input  vram_pkg::pos_t        display_vpos_i,
    input  logic                  fifo_empty_i,
    input  vram_pkg::vram_write_t fifo_head_i,
    output logic                  fifo_pop_o,
    input  logic                  phy_idle_i,
    input  logic                  phy_done_i,
    output logic                  req_valid_o,
    output vram_pkg::qspi_req_t   req_o,
    output logic                  fetch_start_o,
    output vram_pkg::row_t        fetch_row_o,
    output logic                  initialized_o
);

    vram_pkg::seq_state_e state_q;
    logic                 initialized_q;
    logic                 fetch_pending_q;
    vram_pkg::row_t       fetch_row_q;
    logic                 fetch_trigger;
    vram_pkg::row_t       trigger_row;
    logic                 in_idle;

    assign initialized_o = initialized_q;
    assign fetch_row_o   = fetch_row_q;
    assign in_idle       = (state_q == vram_pkg::st_idle);

    // fetch row r on the raster line just before it is shown
    assign fetch_trigger = initialized_q && (display_hpos_i == '0) &&
        (display_vpos_i >= vram_pkg::pos_t'(vram_pkg::HACK_V_OFFSET - 1)) &&
        (display_vpos_i < vram_pkg::pos_t'(vram_pkg::HACK_V_OFFSET +
                                           vram_pkg::HACK_SCREEN_HEIGHT - 1));
    assign trigger_row = vram_pkg::row_t'(display_vpos_i -
                                          vram_pkg::pos_t'(vram_pkg::HACK_V_OFFSET - 1));

    // fetches win over queued writes
    assign fetch_start_o = in_idle && phy_idle_i && fetch_pending_q;
    assign fifo_pop_o    = in_idle && phy_idle_i && !fetch_pending_q && !fifo_empty_i;

    always_comb begin
        case (state_q)
            vram_pkg::st_reset_io,
            vram_pkg::st_enter_quad: req_valid_o = phy_idle_i;
            vram_pkg::st_idle:       req_valid_o = fetch_start_o || fifo_pop_o;
            default:                 req_valid_o = 1'b0;
        endcase
    end

    always_comb begin
        req_o.op   = vram_pkg::op_write_word;
        req_o.addr = vram_pkg::sram_addr_t'({fifo_head_i.addr, 1'b0});
        req_o.data = fifo_head_i.data;
        case (state_q)
            vram_pkg::st_reset_io: begin
                req_o.op = vram_pkg::op_rstio;
            end
            vram_pkg::st_enter_quad: begin
                req_o.op = vram_pkg::op_eqio;
            end
            default: begin
                if (fetch_pending_q) begin
                    req_o.op   = vram_pkg::op_read_row;
                    req_o.addr = vram_pkg::sram_addr_t'(fetch_row_q) *
                                 vram_pkg::sram_addr_t'(2 * vram_pkg::WORDS_PER_ROW);
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q         <= vram_pkg::st_reset_io;
            initialized_q   <= 1'b0;
            fetch_pending_q <= 1'b0;
        end else begin
            if (fetch_trigger) begin
                fetch_pending_q <= 1'b1;
            end else if (fetch_start_o) begin
                fetch_pending_q <= 1'b0;
            end
            case (state_q)
                vram_pkg::st_reset_io: begin
                    if (phy_done_i) begin
                        state_q <= vram_pkg::st_enter_quad;
                    end
                end
                vram_pkg::st_enter_quad: begin
                    if (phy_done_i) begin
                        state_q       <= vram_pkg::st_idle;
                        initialized_q <= 1'b1;
                    end
                end
                vram_pkg::st_idle: begin
                    if (fetch_start_o) begin
                        state_q <= vram_pkg::st_read;
                    end else if (fifo_pop_o) begin
                        state_q <= vram_pkg::st_write;
                    end
                end
                default: begin
                    // read or write in flight
                    if (phy_done_i) begin
                        state_q <= vram_pkg::st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_trigger) begin
            fetch_row_q <= trigger_row;
        end
    end

endmodule

// ==== hw/line_buffer.sv ====
`timescale 1ns/10ps

module line_buffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_start_i,
    input  vram_pkg::row_t    fetch_row_i,
    input  logic              nib_valid_i,
    input  vram_pkg::nibble_t nib_i,
    input  vram_pkg::pos_t    display_hpos_i,
    input  vram_pkg::pos_t    display_vpos_i,
    input  logic              display_active_i,
    output logic              pixel_o
);

    logic [vram_pkg::HACK_SCREEN_WIDTH-1:0]        rows_q [2];
    logic [$clog2(vram_pkg::NIBBLES_PER_ROW)-1:0] wr_pos_q;
    logic                                         fill_half_q;
    vram_pkg::pos_t                               col;
    vram_pkg::pos_t                               line;
    logic                                         in_cols;
    logic                                         in_rows;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_pos_q    <= '0;
            fill_half_q <= 1'b0;
        end else if (fetch_start_i) begin
            wr_pos_q    <= '0;
            fill_half_q <= fetch_row_i[0];
        end else if (nib_valid_i) begin
            wr_pos_q <= wr_pos_q + 1'b1;
        end
    end

    // sio3 carries the leftmost pixel of each nibble
    always_ff @(posedge clk) begin
        if (nib_valid_i) begin
            rows_q[fill_half_q][{wr_pos_q, 2'b00} +: 4] <= {nib_i[0], nib_i[1], nib_i[2], nib_i[3]};
        end
    end

    assign col  = display_hpos_i - vram_pkg::pos_t'(vram_pkg::HACK_H_OFFSET);
    assign line = display_vpos_i - vram_pkg::pos_t'(vram_pkg::HACK_V_OFFSET);

    assign in_cols = (display_hpos_i >= vram_pkg::pos_t'(vram_pkg::HACK_H_OFFSET)) &&
        (display_hpos_i < vram_pkg::pos_t'(vram_pkg::HACK_H_OFFSET +
                                           vram_pkg::HACK_SCREEN_WIDTH));
    assign in_rows = (display_vpos_i >= vram_pkg::pos_t'(vram_pkg::HACK_V_OFFSET)) &&
        (display_vpos_i < vram_pkg::pos_t'(vram_pkg::HACK_V_OFFSET +
                                           vram_pkg::HACK_SCREEN_HEIGHT));

    // a set bit is a black pixel on the hack screen
    assign pixel_o = display_active_i && in_cols && in_rows && !rows_q[line[0]][col[8:0]];

endmodule

// ==== hw/spi_video_ram.sv ====
`timescale 1ns/10ps

module spi_video_ram (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write_strobe_i,
    input  vram_pkg::vram_addr_t write_addr_i,
    input  vram_pkg::word_t      write_data_i,
    input  vram_pkg::pos_t       display_hpos_i,
    input  vram_pkg::pos_t       display_vpos_i,
    input  logic                 display_active_i,
    output logic                 pixel_o,
    output logic                 initialized_o,
    output logic                 sram_cs_n_o,
    output logic                 sram_sck_o,
    output logic                 sram_sio_oe_o,
    output vram_pkg::nibble_t    sram_sio_o,
    input  vram_pkg::nibble_t    sram_sio_i
);

    vram_pkg::vram_write_t cpu_write;
    vram_pkg::vram_write_t fifo_head;
    vram_pkg::qspi_req_t   phy_req;
    vram_pkg::row_t        fetch_row;
    vram_pkg::nibble_t     nib;
    logic                  fifo_push;
    logic                  fifo_pop;
    logic                  fifo_empty;
    logic                  fifo_full;
    logic                  phy_idle;
    logic                  phy_done;
    logic                  req_valid;
    logic                  fetch_start;
    logic                  nib_valid;

    // no back-pressure toward the cpu
    assign cpu_write = '{addr: write_addr_i, data: write_data_i};
    assign fifo_push = write_strobe_i && !fifo_full;

    vram_write_fifo u_fifo (
        .clk         (clk),
        .reset       (reset),
        .push_i      (fifo_push),
        .push_data_i (cpu_write),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full)
    );

    vram_sequencer u_seq (
        .clk            (clk),
        .reset          (reset),
        .display_hpos_i (display_hpos_i),
        .display_vpos_i (display_vpos_i),
        .fifo_empty_i   (fifo_empty),
        .fifo_head_i    (fifo_head),
        .fifo_pop_o     (fifo_pop),
        .phy_idle_i     (phy_idle),
        .phy_done_i     (phy_done),
        .req_valid_o    (req_valid),
        .req_o          (phy_req),
        .fetch_start_o  (fetch_start),
        .fetch_row_o    (fetch_row),
        .initialized_o  (initialized_o)
    );

    sram_qspi_phy u_phy (
        .clk           (clk),
        .reset         (reset),
        .req_valid_i   (req_valid),
        .req_i         (phy_req),
        .idle_o        (phy_idle),
        .done_o        (phy_done),
        .nib_valid_o   (nib_valid),
        .nib_o         (nib),
        .sram_cs_n_o   (sram_cs_n_o),
        .sram_sck_o    (sram_sck_o),
        .sram_sio_oe_o (sram_sio_oe_o),
        .sram_sio_o    (sram_sio_o),
        .sram_sio_i    (sram_sio_i)
    );

    line_buffer u_line_buf (
        .clk              (clk),
        .reset            (reset),
        .fetch_start_i    (fetch_start),
        .fetch_row_i      (fetch_row),
        .nib_valid_i      (nib_valid),
        .nib_i            (nib),
        .display_hpos_i   (display_hpos_i),
        .display_vpos_i   (display_vpos_i),
        .display_active_i (display_active_i),
        .pixel_o          (pixel_o)
    );

endmodule

// ==== testbench/sram_23lc1024_model.sv ====
`timescale 1ns/10ps

module sram_23lc1024_model (
    input  logic              cs_n_i,
    input  logic              sck_i,
    input  logic              sio_oe_i,
    input  vram_pkg::nibble_t sio_i,
    output vram_pkg::nibble_t sio_o,
    output logic              framing_error_o
);

    logic [7:0]  mem [0:131071];
    logic        quad_q;
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [16:0] byte_addr;
    int          sck_cnt;
    int          idx;

    // memory starts out cleared
    initial begin
        for (int i = 0; i < 131072; i++) begin
            mem[i] = 8'h00;
        end
        quad_q          = 1'b0;
        sck_cnt         = 0;
        cmd             = 8'h00;
        addr            = '0;
        sio_o           = 4'h0;
        framing_error_o = 1'b0;
    end

    always @(negedge cs_n_i) begin
        sck_cnt = 0;
        cmd     = 8'h00;
    end

    // framing of quad writes is checked when chip select rises
    always @(posedge cs_n_i) begin
        if (quad_q && cmd == vram_pkg::INS_WRITE && sck_cnt != vram_pkg::QUAD_WRITE_SCK) begin
            $display("sram model saw a quad write of %0d serial clocks at %0t", sck_cnt, $time);
            framing_error_o = 1'b1;
        end
    end

    always @(posedge sck_i) begin
        if (!cs_n_i) begin
            sck_cnt = sck_cnt + 1;
            if (!quad_q) begin
                cmd = {cmd[6:0], sio_i[0]};
                if (sck_cnt == 8 && cmd == vram_pkg::INS_EQIO) begin
                    quad_q = 1'b1;
                end
            end else if (sck_cnt <= 2) begin
                cmd = {cmd[3:0], sio_i};
            end else if (sck_cnt <= 8) begin
                addr = {addr[19:0], sio_i};
            end else if (cmd == vram_pkg::INS_WRITE) begin
                if (!sio_oe_i) begin
                    $display("sram model saw write data with the bus released at %0t", $time);
                    framing_error_o = 1'b1;
                end
                idx       = sck_cnt - 9;
                byte_addr = 17'(addr + 24'(idx / 2));
                if (idx % 2 == 0) begin
                    mem[byte_addr][7:4] = sio_i;
                end else begin
                    mem[byte_addr][3:0] = sio_i;
                end
            end else if (cmd == vram_pkg::INS_READ && sio_oe_i) begin
                $display("sram model saw the bus still driven during a read at %0t", $time);
                framing_error_o = 1'b1;
            end
        end
    end

    // read nibbles change on the falling edge
    // high nibble of each byte goes first
    always @(negedge sck_i) begin
        if (!cs_n_i && quad_q && cmd == vram_pkg::INS_READ && sck_cnt >= 10) begin
            idx       = sck_cnt - 10;
            byte_addr = 17'(addr + 24'(idx / 2));
            sio_o     = (idx % 2 == 0) ? mem[byte_addr][7:4] : mem[byte_addr][3:0];
        end
    end

endmodule

// ==== testbench/spi_video_ram_chk.sv ====
`timescale 1ns/10ps

module spi_video_ram_chk (
    input logic           clk,
    input logic           reset,
    input vram_pkg::pos_t display_hpos_i,
    input vram_pkg::pos_t display_vpos_i,
    input logic           display_active_i,
    input logic           pixel_o,
    input logic           initialized_o,
    input logic           sram_cs_n_o,
    input logic           sram_sck_o,
    input logic           sram_sio_oe_o
);

    logic in_area;

    assign in_area = (display_hpos_i >= 10'(vram_pkg::HACK_H_OFFSET)) &&
        (display_hpos_i < 10'(vram_pkg::HACK_H_OFFSET + vram_pkg::HACK_SCREEN_WIDTH)) &&
        (display_vpos_i >= 10'(vram_pkg::HACK_V_OFFSET)) &&
        (display_vpos_i < 10'(vram_pkg::HACK_V_OFFSET + vram_pkg::HACK_SCREEN_HEIGHT));

    a_idle_pins: assert property (@(posedge clk) disable iff (reset)
        sram_cs_n_o |-> (!sram_sck_o && sram_sio_oe_o))
        else $error("serial clock or bus driver active while chip select is high");

    a_blank_pixel: assert property (@(posedge clk) disable iff (reset)
        (!display_active_i || !in_area) |-> !pixel_o)
        else $error("pixel lit outside the hack area");

    a_init_low: assert property (@(posedge clk) reset |=> !initialized_o)
        else $error("initialized set right after reset");

    // setup ends with a finished transaction
    a_init_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(initialized_o) |-> sram_cs_n_o)
        else $error("initialized rose mid transaction");

endmodule

bind spi_video_ram spi_video_ram_chk u_chk (
    .clk              (clk),
    .reset            (reset),
    .display_hpos_i   (display_hpos_i),
    .display_vpos_i   (display_vpos_i),
    .display_active_i (display_active_i),
    .pixel_o          (pixel_o),
    .initialized_o    (initialized_o),
    .sram_cs_n_o      (sram_cs_n_o),
    .sram_sck_o       (sram_sck_o),
    .sram_sio_oe_o    (sram_sio_oe_o)
);

// ==== testbench/tb_spi_video_ram.sv ====
`timescale 1ns/10ps

module tb_spi_video_ram;

    localparam int FRAME_CYCLES  = 800 * 525;
    localparam int WRITE_COUNT   = 12;
    localparam int WRITE_GAP     = 40;
    localparam int WRITE_CYCLES  = WRITE_COUNT * WRITE_GAP + vram_pkg::FIFO_DEPTH * WRITE_GAP;
    localparam int INIT_LIMIT    = 1000;
    localparam int WATCHDOG      = 2 * FRAME_CYCLES + WRITE_CYCLES + INIT_LIMIT + 100;

    logic                 clk;
    logic                 reset;
    logic                 write_strobe;
    vram_pkg::vram_addr_t write_addr;
    vram_pkg::word_t      write_data;
    vram_pkg::pos_t       hpos;
    vram_pkg::pos_t       vpos;
    logic                 active;
    logic                 pixel;
    logic                 initialized;
    logic                 cs_n;
    logic                 sck;
    logic                 sio_oe;
    vram_pkg::nibble_t    sio_out;
    vram_pkg::nibble_t    sio_in;
    logic                 framing_error;

    vram_pkg::word_t      shadow [0:127];
    vram_pkg::vram_addr_t written [$];
    logic [31:0]          lcg_state;
    int                   errors;
    int                   idle_errors;
    int                   tests_failed;
    int                   mark;
    logic                 checking_idle;

    spi_video_ram uut (
        .clk(clk), .reset(reset),
        .write_strobe_i(write_strobe), .write_addr_i(write_addr), .write_data_i(write_data),
        .display_hpos_i(hpos), .display_vpos_i(vpos), .display_active_i(active),
        .pixel_o(pixel), .initialized_o(initialized),
        .sram_cs_n_o(cs_n), .sram_sck_o(sck), .sram_sio_oe_o(sio_oe),
        .sram_sio_o(sio_out), .sram_sio_i(sio_in)
    );

    sram_23lc1024_model u_sram (
        .cs_n_i(cs_n), .sck_i(sck), .sio_oe_i(sio_oe), .sio_i(sio_out),
        .sio_o(sio_in), .framing_error_o(framing_error)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
    endfunction

    function automatic vram_pkg::word_t reverse_word(input vram_pkg::word_t w);
        vram_pkg::word_t r;
        for (int i = 0; i < 16; i++) begin
            r[i] = w[15-i];
        end
        return r;
    endfunction

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    task automatic cpu_write(input vram_pkg::vram_addr_t a, input vram_pkg::word_t d);
        @(posedge clk);
        write_strobe <= 1'b1;
        write_addr   <= a;
        write_data   <= d;
        @(posedge clk);
        write_strobe <= 1'b0;
        repeat (WRITE_GAP - 2) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 800x525 raster with a 640x480 active window
    always @(posedge clk) begin
        if (hpos == 10'd799) begin
            hpos <= '0;
            vpos <= (vpos == 10'd524) ? 10'd0 : vpos + 1'b1;
        end else begin
            hpos <= hpos + 1'b1;
        end
    end
    assign active = (hpos < 10'd640) && (vpos < 10'd480);

    always @(negedge clk) begin
        if (checking_idle && cs_n === 1'b1) begin
            assert (sck === 1'b0 && sio_oe === 1'b1) else begin
                $display("FAILED %0t sram_sck_o/sram_sio_oe_o expected 0/1 got %b/%b",
                         $time, sck, sio_oe);
                idle_errors++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        vram_pkg::word_t got;
        vram_pkg::word_t expv;
        logic            exp_pix;
        int              cnt;
        int              row;
        int              col;
        reset         = 1'b1;
        write_strobe  = 1'b0;
        write_addr    = '0;
        write_data    = '0;
        hpos          = '0;
        vpos          = '0;
        errors        = 0;
        idle_errors   = 0;
        tests_failed  = 0;
        checking_idle = 1'b0;
        lcg_state     = 32'd33105;
        for (int i = 0; i < 128; i++) begin
            shadow[i] = '0;
        end

        // reset state and initialisation
        mark = errors;
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (cs_n === 1'b1 && initialized === 1'b0) else begin
            $display("FAILED %0t sram_cs_n_o/initialized_o expected 1/0 got %b/%b",
                     $time, cs_n, initialized);
            errors++;
        end
        @(posedge clk);
        reset <= 1'b0;
        checking_idle = 1'b1;
        cnt = 0;
        while (initialized !== 1'b1 && cnt < INIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        assert (initialized === 1'b1) else begin
            $display("initialized_o never rose after reset");
            errors++;
        end
        report_test("reset and init", mark);

        // cpu writes land bit reversed in the sram
        mark = errors;
        for (int i = 0; i < WRITE_COUNT; i++) begin
            lcg_state = lcg_next(lcg_state);
            write_addr_pick: begin
                vram_pkg::vram_addr_t a;
                vram_pkg::word_t      d;
                a = vram_pkg::vram_addr_t'(lcg_state[20:8] % 13'd128);
                lcg_state = lcg_next(lcg_state);
                d = lcg_state[23:8];
                shadow[a] = d;
                written.push_back(a);
                cpu_write(a, d);
            end
        end
        repeat (vram_pkg::FIFO_DEPTH * WRITE_GAP) @(posedge clk);
        foreach (written[i]) begin
            got  = {u_sram.mem[2 * written[i]], u_sram.mem[2 * written[i] + 1]};
            expv = reverse_word(shadow[written[i]]);
            assert (got === expv) else begin
                $display("FAILED %0t u_sram.mem word %0d expected %h got %h",
                         $time, written[i], expv, got);
                errors++;
            end
        end
        assert (framing_error === 1'b0) else begin
            $display("the sram model reported bad quad framing");
            errors++;
        end
        report_test("cpu writes", mark);

        // one whole frame of pixels
        mark = errors;
        @(negedge clk);
        while (!(hpos == '0 && vpos == '0)) begin
            @(negedge clk);
        end
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            row = int'(vpos) - vram_pkg::HACK_V_OFFSET;
            col = int'(hpos) - vram_pkg::HACK_H_OFFSET;
            exp_pix = 1'b0;
            if (active && row >= 0 && row < vram_pkg::HACK_SCREEN_HEIGHT &&
                col >= 0 && col < vram_pkg::HACK_SCREEN_WIDTH) begin
                exp_pix = (row < 4) ? !shadow[row * 32 + col / 16][col % 16] : 1'b1;
            end
            assert (pixel === exp_pix) else begin
                $display("FAILED %0t pixel_o expected %b got %b", $time, exp_pix, pixel);
                errors++;
            end
            @(negedge clk);
        end
        report_test("display frame", mark);

        mark = errors;
        errors += idle_errors;
        report_test("idle pins", mark);

        $display("tests failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== spi_video_ram.f ====
hw/vram_pkg.sv
hw/vram_write_fifo.sv
hw/sram_qspi_phy.sv
hw/vram_sequencer.sv
hw/line_buffer.sv
hw/spi_video_ram.sv
testbench/sram_23lc1024_model.sv
testbench/spi_video_ram_chk.sv
testbench/tb_spi_video_ram.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench, success only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_video_ram -f spi_video_ram.f -o vtb_spi_video_ram \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/vtb_spi_video_ram | tee /dev/stderr | grep -qx "Simulation passed" \
    && exit 0 \
    || exit 1
